//--- tests/cpu_core_tests.txt
// Program words from address 0; @80 marks the expected writeback records
// Record columns: register, value, NZCV held while the write is on the bus; ffffffff ends the list
@0
E3A000FF  // 00 mov r0, #0xff
E3A012FF  // 04 mov r1, #0xf000000f
E2802C01  // 08 add r2, r0, #0x100
E3803C3F  // 0c orr r3, r0, #0x3f00
E1A04201  // 10 mov r4, r1, lsl #4
E0805E21  // 14 add r5, r0, r1, lsr #28
E1A06441  // 18 mov r6, r1, asr #8
E1A07060  // 1c mov r7, r0, rrx
E1B080A1  // 20 movs r8, r1, lsr #1
E1A09060  // 24 mov r9, r0, rrx
E3A0B008  // 28 mov r11, #8
E1A0AB71  // 2c mov r10, r1, ror r11
E080CB1F  // 30 add r12, r0, pc, lsl r11
E35000FF  // 34 cmp r0, #0xff
03A01001  // 38 moveq r1, #1
13A02002  // 3c movne r2, #2
E3700001  // 40 cmn r0, #1
03A03003  // 44 moveq r3, #3
E3100C01  // 48 tst r0, #0x100
13A03003  // 4c movne r3, #3
E33600FF  // 50 teq r6, #0xff
43A04004  // 54 movmi r4, #4
53A05005  // 58 movpl r5, #5
E3A0F080  // 5c mov pc, #0x80
E3A000EE  // 60 mov r0, #0xee, flushed away
@20
E3A0D05A  // 80 mov r13, #0x5a
E25DE05A  // 84 subs r14, r13, #0x5a
01A0008D  // 88 moveq r0, r13, lsl #1
@80
0 000000ff 0
1 f000000f 0
2 000001ff 0
3 00003fff 0
4 000000f0 0
5 0000010e 0
6 fff00000 0
7 0000007f 0
8 78000007 0
9 8000007f 2
b 00000008 2
a 0ff00000 2
c 00003cff 2
1 00000001 6
4 00000004 8
f 00000080 8
d 0000005a 8
e 00000000 8
0 000000b4 6
ffffffff

//--- compile.f
logic/cpu_types_pkg.sv
logic/control_types_pkg.sv
logic/decoder_if.sv
logic/instr_decoder.sv
logic/control_unit.sv
logic/barrel_shifter.sv
logic/alu.sv
logic/register_file.sv
logic/cpu_core.sv
tests/cpu_core_tb.sv

//--- Makefile
LOG = sim.log

.PHONY: all compile run check clean

all: check

compile:
	verilator --binary --timing -Wno-fatal --timescale 1ns/1ps -f compile.f --top-module cpu_core_tb -o cpu_core_tb

run: compile
	./obj_dir/cpu_core_tb | tee $(LOG)

check: run
	@grep -qx "Simulation PASSED" $(LOG) || (echo "Pass message not found in $(LOG)"; exit 1)

clean:
	rm -rf obj_dir $(LOG)

//--- tests/cpu_core_tb.sv
`timescale 1ns/1ps

module cpu_core_tb import cpu_types_pkg::*; ();

  localparam word_t SEED       = 32'h707b_6803;
  localparam word_t RESET_PC   = 32'h0;
  localparam int    MEM_WORDS  = 256;
  localparam int    PROG_WORDS = 128;
  localparam int    REC_BASE   = 128;
  localparam int    MAX_RECS   = (MEM_WORDS - REC_BASE) / 3;
  localparam int    TIMEOUT    = 50;
  localparam int    RUNS       = 2;
  localparam word_t END_MARK   = 32'hffff_ffff;

  logic     clk;
  logic     reset;
  word_t    mem_rdata;
  word_t    mem_addr;
  logic     mem_read_en;
  logic     reg_wr_en;
  reg_idx_t reg_wr_addr;
  word_t    reg_wr_data;
  flags_t   flags;

  // Program below REC_BASE, expected writeback records from REC_BASE on
  word_t tests_mem [MEM_WORDS];
  int    rec_count;
  int    value_errors;
  int    other_errors;

  cpu_core #(.RESET_PC(RESET_PC)) u_dut (
    .clk,
    .reset,
    .mem_rdata,
    .mem_addr,
    .mem_read_en,
    .reg_wr_en,
    .reg_wr_addr,
    .reg_wr_data,
    .flags
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // ==============================
  // Instruction memory
  // ==============================

  // Stray fetches carry condition NV and never write back
  function automatic word_t fill_word(input word_t addr);
    return {4'hF, addr[29:2] ^ {24'd0, addr[31:30], addr[1:0]}};
  endfunction

  function automatic word_t fetch_word(input word_t addr);
    word_t idx;
    idx = addr >> 2;
    if (idx < PROG_WORDS) return tests_mem[idx[7:0]];
    return fill_word(addr);
  endfunction

  // Read data shows up one cycle after the strobe
  always @(posedge clk) begin
    if (mem_read_en === 1'b1) begin
      mem_rdata <= fetch_word(mem_addr);
    end
  end

  task automatic load_memory();
    for (int i = 0; i < MEM_WORDS; i++) begin
      tests_mem[i] = fill_word(word_t'(i) << 2);
    end
    $readmemh("tests/cpu_core_tests.txt", tests_mem);

    rec_count = 0;
    while (rec_count < MAX_RECS && tests_mem[REC_BASE + 3 * rec_count] != END_MARK) begin
      rec_count++;
    end
    if (rec_count == 0 || rec_count == MAX_RECS) begin
      $display("Test data holds no expected records ending in the end marker");
      other_errors++;
      rec_count = 0;
    end
  endtask

  // ==============================
  // Compare tasks
  // ==============================

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("** Error at %0t ns: %s is %b, expected %b", $time, name, got, exp);
      value_errors++;
    end
  endtask

  task automatic check_reg_idx(input string name, input reg_idx_t got, input reg_idx_t exp);
    if (got !== exp) begin
      $display("** Error at %0t ns: %s is %0d, expected %0d", $time, name, got, exp);
      value_errors++;
    end
  endtask

  task automatic check_word(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      $display("** Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
      value_errors++;
    end
  endtask

  task automatic check_flags(input string name, input flags_t got, input flags_t exp);
    if (got !== exp) begin
      $display("** Error at %0t ns: %s is %b, expected %b", $time, name, got, exp);
      value_errors++;
    end
  endtask

  task automatic check_record(input int k);
    int base;
    base = REC_BASE + 3 * k;
    check_reg_idx("reg_wr_addr", reg_wr_addr, tests_mem[base][3:0]);
    check_word("reg_wr_data", reg_wr_data, tests_mem[base + 1]);
    check_flags("flags", flags, tests_mem[base + 2][3:0]);
  endtask

  // ==============================
  // Sequencing
  // ==============================

  task automatic apply_reset();
    reset <= 1'b1;
    load_memory();
    repeat (5) @(posedge clk);
    reset <= 1'b0;
  endtask

  // First strobe comes in the second cycle after reset falls, at the reset PC
  task automatic check_first_fetch();
    @(posedge clk);
    check_bit("mem_read_en", mem_read_en, 1'b0);
    @(posedge clk);
    check_bit("mem_read_en", mem_read_en, 1'b1);
    check_word("mem_addr", mem_addr, RESET_PC);
  endtask

  task automatic wait_writeback(output logic seen);
    int n;
    seen = 1'b0;
    n = 0;
    while (!seen && n < TIMEOUT) begin
      @(posedge clk);
      if (reg_wr_en === 1'b1) begin
        seen = 1'b1;
      end else begin
        n++;
      end
    end
  endtask

  // No write may appear once the record list is used up
  task automatic check_idle(input int cycles);
    repeat (cycles) begin
      @(posedge clk);
      if (reg_wr_en !== 1'b0) begin
        $display("Unexpected writeback to R%0d at %0t ns after the last expected one",
                 reg_wr_addr, $time);
        other_errors++;
      end
    end
  endtask

  initial begin
    logic        seen;
    logic        aborted;
    int unsigned gap;
    reset        = 1'b1;
    mem_rdata    = '0;
    value_errors = 0;
    other_errors = 0;
    rec_count    = 0;
    aborted      = 1'b0;
    void'($urandom(SEED));

    for (int run = 0; run < RUNS && !aborted; run++) begin
      apply_reset();
      check_first_fetch();
      for (int k = 0; k < rec_count && !aborted; k++) begin
        wait_writeback(seen);
        if (seen) begin
          check_record(k);
        end else begin
          $display("Timed out after %0d cycles waiting for writeback %0d in run %0d",
                   TIMEOUT, k, run);
          other_errors++;
          aborted = 1'b1;
        end
      end
      if (!aborted) begin
        gap = 5 + ($urandom % 16);
        check_idle(gap);
      end
    end

    $display("Errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

//--- logic/cpu_core.sv
`timescale 1ns/1ps

module cpu_core import cpu_types_pkg::*, control_types_pkg::*; #(
  parameter word_t RESET_PC = 32'h0
) (
  input  logic     clk,
  input  logic     reset,
  input  word_t    mem_rdata,
  output word_t    mem_addr,
  output logic     mem_read_en,
  output logic     reg_wr_en,
  output reg_idx_t reg_wr_addr,
  output word_t    reg_wr_data,
  output flags_t   flags
);

  decoder_if dec_bus ();

  control_t ctrl;
  word_t    rn_data, rm_data, rs_data, pc;
  word_t    shifter_out, alu_result;
  logic     shifter_carry;
  logic     flush_req;

  instr_decoder u_decoder (
    .clk, .reset, .mem_rdata, .bus(dec_bus.decoder_side)
  );

  control_unit u_control (
    .clk, .reset, .decoder_bus(dec_bus.control_side), .flush_req,
    .control_signals(ctrl)
  );

  register_file #(.RESET_PC(RESET_PC)) u_regs (
    .clk, .reset, .ctrl,
    .rn_idx(dec_bus.word.rn), .rm_idx(dec_bus.word.rm),
    .rs_idx(dec_bus.word.rs), .rd_idx(dec_bus.word.rd),
    .wr_data(alu_result), .rn_data, .rm_data, .rs_data, .pc,
    .wr_en(reg_wr_en), .flush_req
  );

  barrel_shifter u_shifter (
    .clk, .reset, .ctrl, .rm_data, .rs_data, .carry_in(dec_bus.flags[1]),
    .shifter_out, .shifter_carry
  );

  alu u_alu (
    .clk, .reset, .ctrl, .op_a(rn_data), .op_b(shifter_out), .shifter_carry,
    .result(alu_result), .flags(dec_bus.flags)
  );

  assign mem_addr    = (ctrl.addr_bus_src == ADDR_SRC_INCR) ? pc + 32'd4 : pc;
  assign mem_read_en = ctrl.memory_read_en;
  assign reg_wr_addr = dec_bus.word.rd;
  assign reg_wr_data = alu_result;
  assign flags       = dec_bus.flags;

endmodule

//--- logic/register_file.sv
`timescale 1ns/1ps

module register_file import cpu_types_pkg::*, control_types_pkg::*; #(
  parameter word_t RESET_PC = 32'h0
) (
  input  logic     clk,
  input  logic     reset,
  input  control_t ctrl,
  input  reg_idx_t rn_idx,
  input  reg_idx_t rm_idx,
  input  reg_idx_t rs_idx,
  input  reg_idx_t rd_idx,
  input  word_t    wr_data,
  output word_t    rn_data,
  output word_t    rm_data,
  output word_t    rs_data,
  output word_t    pc,
  output logic     wr_en,
  output logic     flush_req
);

  word_t regs [15];
  word_t pc_q;

  // The fetch pointer runs one word ahead, so pc_q + 4 is the executing address plus 8
  function automatic word_t read_port(input reg_idx_t idx, input logic add_4);
    if (idx == 4'd15) return pc_q + 32'd4 + (add_4 ? 32'd4 : 32'd0);
    return regs[idx];
  endfunction

  assign rn_data = read_port(rn_idx, ctrl.pc_rn_add_4);
  assign rm_data = read_port(rm_idx, ctrl.pc_rm_add_4);
  assign rs_data = read_port(rs_idx, ctrl.pc_rs_add_4);
  assign pc      = pc_q;
  assign wr_en   = ctrl.alu_writeback == ALU_WB_REG_RD;

  always_ff @(posedge clk) begin
    if (wr_en && rd_idx != 4'd15) begin
      regs[rd_idx] <= wr_data;
    end
  end

  // ALU writes to R15 win over the incrementer
  always_ff @(posedge clk) begin
    if (reset) begin
      pc_q      <= RESET_PC;
      flush_req <= 1'b0;
    end else begin
      flush_req <= wr_en && rd_idx == 4'd15;
      if (wr_en && rd_idx == 4'd15) begin
        pc_q <= wr_data;
      end else if (ctrl.incrementer_writeback) begin
        pc_q <= pc_q + 32'd4;
      end
    end
  end

endmodule

//--- logic/alu.sv
`timescale 1ns/1ps

module alu import cpu_types_pkg::*, control_types_pkg::*; (
  input  logic     clk,
  input  logic     reset,
  input  control_t ctrl,
  input  word_t    op_a,
  input  word_t    op_b,
  input  logic     shifter_carry,
  output word_t    result,
  output flags_t   flags
);

  logic [32:0] sum;
  word_t       x;
  word_t       y;
  logic        cin;
  logic        arith;
  logic        c_out;
  logic        v_out;

  always_comb begin
    arith = 1'b1;
    x     = op_a;
    y     = op_b;
    cin   = 1'b0;
    case (ctrl.ALU_op)
      ALU_OP_SUB, ALU_OP_CMP: begin
        y   = ~op_b;
        cin = 1'b1;
      end
      ALU_OP_RSB: begin
        x   = op_b;
        y   = ~op_a;
        cin = 1'b1;
      end
      ALU_OP_ADC: cin = flags[1];
      ALU_OP_SBC: begin
        y   = ~op_b;
        cin = flags[1];
      end
      ALU_OP_RSC: begin
        x   = op_b;
        y   = ~op_a;
        cin = flags[1];
      end
      ALU_OP_ADD, ALU_OP_CMP_NEG: ;
      default: arith = 1'b0;
    endcase

    sum = {1'b0, x} + {1'b0, y} + {32'd0, cin};

    case (ctrl.ALU_op)
      ALU_OP_AND, ALU_OP_TEST:           result = op_a & op_b;
      ALU_OP_EOR, ALU_OP_TEST_EXCLUSIVE: result = op_a ^ op_b;
      ALU_OP_ORR:                        result = op_a | op_b;
      ALU_OP_MOV:                        result = op_b;
      ALU_OP_BIC:                        result = op_a & ~op_b;
      ALU_OP_MVN:                        result = ~op_b;
      default:                           result = sum[31:0];
    endcase

    // Logical ops take C from the shifter and keep V
    c_out = arith ? sum[32] : shifter_carry;
    v_out = arith ? ((x[31] == y[31]) && (sum[31] != x[31])) : flags[0];
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      flags <= '0;
    end else if (ctrl.ALU_set_flags) begin
      flags <= {result[31], result == 32'd0, c_out, v_out};
    end
  end

endmodule

//--- logic/barrel_shifter.sv
`timescale 1ns/1ps

module barrel_shifter import cpu_types_pkg::*, control_types_pkg::*; (
  input  logic     clk,
  input  logic     reset,
  input  control_t ctrl,
  input  word_t    rm_data,
  input  word_t    rs_data,
  input  logic     carry_in,
  output word_t    shifter_out,
  output logic     shifter_carry
);

  logic [7:0]  amt_latch;
  logic [7:0]  amt;
  logic [5:0]  amt_sat;
  word_t       b;
  logic [32:0] ext;

  always_ff @(posedge clk) begin
    if (reset) begin
      amt_latch <= 8'd0;
    end else if (ctrl.shift_latch_amt) begin
      amt_latch <= b[7:0];
    end
  end

  always_comb begin
    case (ctrl.B_bus_source)
      B_BUS_SRC_IMM:    b = {20'd0, ctrl.B_bus_imm};
      B_BUS_SRC_REG_RS: b = rs_data;
      default:          b = rm_data;
    endcase

    amt     = ctrl.shift_use_latch ? amt_latch : {3'd0, ctrl.shift_amount};
    // Anything past 32 behaves like 32 for ASR
    amt_sat = (amt > 8'd32) ? 6'd32 : amt[5:0];
    ext     = '0;
    shifter_out   = b;
    shifter_carry = carry_in;

    if (ctrl.shift_use_rrx) begin
      shifter_out   = {carry_in, b[31:1]};
      shifter_carry = b[0];
    end else if (amt != 8'd0) begin
      case (ctrl.shift_type)
        SHIFT_LSL: begin
          ext = (amt > 8'd32) ? 33'd0 : ({1'b0, b} << amt_sat);
          shifter_out   = ext[31:0];
          shifter_carry = ext[32];
        end
        SHIFT_LSR: begin
          ext = (amt > 8'd32) ? 33'd0 : ({b, 1'b0} >> amt_sat);
          shifter_out   = ext[32:1];
          shifter_carry = ext[0];
        end
        SHIFT_ASR: begin
          ext = $signed({b, 1'b0}) >>> amt_sat;
          shifter_out   = ext[32:1];
          shifter_carry = ext[0];
        end
        default: begin
          shifter_out   = (b >> amt[4:0]) | (b << (6'd32 - {1'b0, amt[4:0]}));
          shifter_carry = shifter_out[31];
        end
      endcase
    end
  end

endmodule

//--- logic/control_unit.sv
`timescale 1ns/1ps

module control_unit import cpu_types_pkg::*, control_types_pkg::*; (
  input  logic     clk,
  input  logic     reset,
  decoder_if.control_side decoder_bus,
  input  logic     flush_req,
  output control_t control_signals
);

  logic [1:0]    cycle;
  logic [2:0]    flush_cnt;
  decoded_word_t curr_instr;

  assign decoder_bus.enable   = control_signals.instr_done;
  assign decoder_bus.latch_ir = control_signals.memory_latch_IR;

  always_ff @(posedge clk) begin
    if (reset || control_signals.instr_done) begin
      cycle <= 2'd0;
    end else begin
      cycle <= cycle + 2'd1;
    end
  end

  // Second cycle of a reg-reg op works from this copy
  always_ff @(posedge clk) begin
    if (cycle == 2'd0) begin
      curr_instr <= decoder_bus.word;
    end
  end

  // Reset starts a full flush to fetch the first instruction
  always_ff @(posedge clk) begin
    if (reset) begin
      flush_cnt <= 3'd3;
    end else if (flush_req) begin
      flush_cnt <= 3'd1;
    end else if (flush_cnt != 3'd0) begin
      flush_cnt <= flush_cnt - 3'd1;
    end
  end

  function automatic alu_wb_t get_alu_writeback(input alu_op_t op, input logic pass);
    if (!pass) return ALU_WB_NONE;
    case (op)
      ALU_OP_CMP, ALU_OP_CMP_NEG, ALU_OP_TEST, ALU_OP_TEST_EXCLUSIVE: return ALU_WB_NONE;
      default: return ALU_WB_REG_RD;
    endcase
  endfunction

  // Fetch the next word and finish the instruction
  function automatic control_t fetch_next(input control_t c);
    control_t r;
    r = c;
    r.memory_read_en        = 1'b1;
    r.memory_latch_IR       = 1'b1;
    r.incrementer_writeback = 1'b1;
    r.addr_bus_src          = ADDR_SRC_INCR;
    r.instr_done            = 1'b1;
    return r;
  endfunction

  always_comb begin
    control_signals = '0;

    if (flush_cnt == 3'd3) begin
      control_signals.addr_bus_src = ADDR_SRC_PC;
    end else if (flush_cnt == 3'd2 || flush_req) begin
      // First fetch from the new PC, which is not advanced yet
      control_signals.memory_read_en  = 1'b1;
      control_signals.memory_latch_IR = 1'b1;
      control_signals.addr_bus_src    = ADDR_SRC_PC;
    end else if (flush_cnt == 3'd1) begin
      control_signals = fetch_next(control_signals);
    end else begin
      case (decoder_bus.word.instr_type)

        // ==============================
        // Immediate with rotate
        // ==============================
        ARM_INSTR_DATAPROC_IMM: begin
          control_signals.B_bus_source  = B_BUS_SRC_IMM;
          control_signals.B_bus_imm     = {4'd0, decoder_bus.word.imm8};
          control_signals.shift_type    = SHIFT_ROR;
          control_signals.shift_amount  = {decoder_bus.word.rotate, 1'b0};
          control_signals.ALU_op        = decoder_bus.word.opcode;
          control_signals.alu_writeback =
              get_alu_writeback(decoder_bus.word.opcode, decoder_bus.word.condition_pass);
          control_signals.ALU_set_flags =
              decoder_bus.word.set_flags && decoder_bus.word.condition_pass;
          control_signals = fetch_next(control_signals);
        end

        // ==============================
        // Register, immediate shift
        // ==============================
        ARM_INSTR_DATAPROC_REG_IMM: begin
          control_signals.B_bus_source  = B_BUS_SRC_REG_RM;
          control_signals.shift_type    = decoder_bus.word.shift_type;
          control_signals.shift_amount  = decoder_bus.word.shift_amount;
          // ROR #0 encodes RRX
          control_signals.shift_use_rrx = decoder_bus.word.shift_type == SHIFT_ROR &&
                                          decoder_bus.word.shift_amount == 5'd0;
          control_signals.ALU_op        = decoder_bus.word.opcode;
          control_signals.alu_writeback =
              get_alu_writeback(decoder_bus.word.opcode, decoder_bus.word.condition_pass);
          control_signals.ALU_set_flags =
              decoder_bus.word.set_flags && decoder_bus.word.condition_pass;
          control_signals = fetch_next(control_signals);
        end

        // ==============================
        // Register, register shift
        // ==============================
        ARM_INSTR_DATAPROC_REG_REG: begin
          if (cycle == 2'd0) begin
            // Internal cycle, no fetch
            control_signals.B_bus_source    = B_BUS_SRC_REG_RS;
            control_signals.shift_latch_amt = 1'b1;
            control_signals.pc_rs_add_4     = decoder_bus.word.rs == 4'd15;
          end else begin
            control_signals.B_bus_source    = B_BUS_SRC_REG_RM;
            control_signals.shift_type      = curr_instr.shift_type;
            control_signals.shift_use_latch = 1'b1;
            control_signals.ALU_op          = curr_instr.opcode;
            control_signals.alu_writeback   =
                get_alu_writeback(curr_instr.opcode, curr_instr.condition_pass);
            control_signals.ALU_set_flags   =
                curr_instr.set_flags && curr_instr.condition_pass;
            control_signals.pc_rn_add_4     = curr_instr.rn == 4'd15;
            control_signals.pc_rm_add_4     = curr_instr.rm == 4'd15;
            control_signals = fetch_next(control_signals);
          end
        end

        // Anything else runs as a no-op
        default: begin
          control_signals = fetch_next(control_signals);
        end
      endcase
    end
  end

endmodule

//--- logic/instr_decoder.sv
`timescale 1ns/1ps

module instr_decoder import cpu_types_pkg::*; (
  input  logic   clk,
  input  logic   reset,
  input  word_t  mem_rdata,
  decoder_if.decoder_side bus
);

  logic  latch_pending;
  word_t fetch_buf;
  word_t ir;
  flags_t f;

  // Memory answers one cycle after the strobe
  always_ff @(posedge clk) begin
    if (reset) begin
      latch_pending <= 1'b0;
    end else begin
      latch_pending <= bus.latch_ir;
    end
  end

  // A word that arrives mid-instruction waits in the buffer until the next decode
  always_ff @(posedge clk) begin
    if (latch_pending) begin
      fetch_buf <= mem_rdata;
    end
    if (bus.enable) begin
      ir <= latch_pending ? mem_rdata : fetch_buf;
    end
  end

  function automatic logic cond_check(input cond_t c, input flags_t fl);
    logic n, z, cf, v;
    {n, z, cf, v} = fl;
    case (c)
      4'h0: return z;
      4'h1: return !z;
      4'h2: return cf;
      4'h3: return !cf;
      4'h4: return n;
      4'h5: return !n;
      4'h6: return v;
      4'h7: return !v;
      4'h8: return cf && !z;
      4'h9: return !cf || z;
      4'hA: return n == v;
      4'hB: return n != v;
      4'hC: return !z && (n == v);
      4'hD: return z || (n != v);
      4'hE: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  assign f = bus.flags;

  always_comb begin
    bus.word.ir             = ir;
    bus.word.opcode         = alu_op_t'(ir[24:21]);
    bus.word.set_flags      = ir[20];
    bus.word.rn             = ir[19:16];
    bus.word.rd             = ir[15:12];
    bus.word.rs             = ir[11:8];
    bus.word.rotate         = ir[11:8];
    bus.word.imm8           = ir[7:0];
    bus.word.shift_amount   = ir[11:7];
    bus.word.shift_type     = shift_t'(ir[6:5]);
    bus.word.rm             = ir[3:0];
    bus.word.condition_pass = cond_check(ir[31:28], f);

    // Compare opcodes without S belong to the misc space
    if (ir[27:26] != 2'b00 || (ir[24:23] == 2'b10 && !ir[20])) begin
      bus.word.instr_type = ARM_INSTR_OTHER;
    end else if (ir[25]) begin
      bus.word.instr_type = ARM_INSTR_DATAPROC_IMM;
    end else if (!ir[4]) begin
      bus.word.instr_type = ARM_INSTR_DATAPROC_REG_IMM;
    end else if (!ir[7]) begin
      bus.word.instr_type = ARM_INSTR_DATAPROC_REG_REG;
    end else begin
      bus.word.instr_type = ARM_INSTR_OTHER;
    end
  end

endmodule

//--- logic/decoder_if.sv
`timescale 1ns/1ps

interface decoder_if import cpu_types_pkg::*; ();

  decoded_word_t word;
  logic          enable;
  logic          latch_ir;
  flags_t        flags;

  modport decoder_side (output word, input enable, input latch_ir, input flags);

  modport control_side (input word, output enable, output latch_ir);

endinterface

//--- logic/control_types_pkg.sv
package control_types_pkg;

  import cpu_types_pkg::*;

  typedef enum logic [1:0] {
    B_BUS_SRC_IMM,
    B_BUS_SRC_REG_RM,
    B_BUS_SRC_REG_RS
  } b_src_t;

  // Fetch address is the PC itself or the incremented PC
  typedef enum logic {
    ADDR_SRC_PC,
    ADDR_SRC_INCR
  } addr_src_t;

  typedef enum logic {
    ALU_WB_NONE,
    ALU_WB_REG_RD
  } alu_wb_t;

  typedef struct packed {
    logic       instr_done;
    logic       memory_read_en;
    logic       memory_latch_IR;
    logic       incrementer_writeback;
    addr_src_t  addr_bus_src;
    b_src_t     B_bus_source;
    logic [11:0] B_bus_imm;
    shift_t     shift_type;
    shamt_t     shift_amount;
    logic       shift_latch_amt;
    logic       shift_use_latch;
    logic       shift_use_rrx;
    alu_op_t    ALU_op;
    logic       ALU_set_flags;
    alu_wb_t    alu_writeback;
    logic       pc_rn_add_4;
    logic       pc_rm_add_4;
    logic       pc_rs_add_4;
  } control_t;

endpackage

//--- logic/cpu_types_pkg.sv
package cpu_types_pkg;

  typedef logic [31:0] word_t;
  typedef logic [3:0]  reg_idx_t;
  typedef logic [3:0]  cond_t;
  typedef logic [4:0]  shamt_t;

  // N Z C V from bit 3 down to bit 0
  typedef logic [3:0]  flags_t;

  typedef enum logic [1:0] {
    SHIFT_LSL,
    SHIFT_LSR,
    SHIFT_ASR,
    SHIFT_ROR
  } shift_t;

  // Data-processing opcodes in encoding order
  typedef enum logic [3:0] {
    ALU_OP_AND,
    ALU_OP_EOR,
    ALU_OP_SUB,
    ALU_OP_RSB,
    ALU_OP_ADD,
    ALU_OP_ADC,
    ALU_OP_SBC,
    ALU_OP_RSC,
    ALU_OP_TEST,
    ALU_OP_TEST_EXCLUSIVE,
    ALU_OP_CMP,
    ALU_OP_CMP_NEG,
    ALU_OP_ORR,
    ALU_OP_MOV,
    ALU_OP_BIC,
    ALU_OP_MVN
  } alu_op_t;

  typedef enum logic [1:0] {
    ARM_INSTR_DATAPROC_IMM,
    ARM_INSTR_DATAPROC_REG_IMM,
    ARM_INSTR_DATAPROC_REG_REG,
    ARM_INSTR_OTHER
  } instr_class_t;

  typedef struct packed {
    instr_class_t instr_type;
    alu_op_t      opcode;
    logic         set_flags;
    reg_idx_t     rn;
    reg_idx_t     rd;
    reg_idx_t     rs;
    reg_idx_t     rm;
    logic [7:0]   imm8;
    logic [3:0]   rotate;
    shift_t       shift_type;
    shamt_t       shift_amount;
    logic         condition_pass;
    word_t        ir;
  } decoded_word_t;

endpackage
